//--- project.f
rtl/opc5_pkg.sv
rtl/opc5_control.sv
rtl/opc5_regfile.sv
rtl/opc5_alu.sv
rtl/opc5_cpu.sv
rtl/opc5_memory.sv
rtl/opc5_apb_port.sv
rtl/opc5_system.sv
verification/opc5_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module opc5_system_tb -f project.f -o opc5_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/opc5_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

//--- verification/opc5_system_tb.sv
`timescale 1ns/1ps

module opc5_system_tb;
   import opc5_pkg::*;

   localparam int mem_words      = 256;
   localparam int num_progs      = 14;
   localparam int num_tests      = num_progs + 4;
   localparam int timeout_cycles = num_tests * 300;
   localparam int run_cycles     = 200;  // Longer than any program needs before it halts

   // Predicate field values {carry enable, zero enable, invert}
   localparam logic [2:0] p_al = 3'b000;
   localparam logic [2:0] p_z  = 3'b010;
   localparam logic [2:0] p_nz = 3'b011;
   localparam logic [2:0] p_c  = 3'b100;

   logic     clk;
   logic     reset_b;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   string       prog_name [num_progs];
   logic [15:0] prog_words [num_progs][12];
   logic [11:0] prog_result_addr [num_progs];
   logic [15:0] prog_expected [num_progs];

   string current_test;
   int    error_count = 0;
   int    errors_at_start = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   int    cycle_count = 0;

   opc5_system #(
      .MEM_WORDS (mem_words)
   ) dut_i (
      .clk     (clk),
      .reset_b (reset_b),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   initial clk = 1'b0;

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles)
      begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_count);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ==================================================
   // Instruction encoding
   // ==================================================
   function automatic logic [15:0] insn_word(input logic [2:0] pred, input logic two_word,
                                             input logic indirect, input alu_op_e op,
                                             input logic [3:0] src, input logic [3:0] dst);
      return {pred, two_word, indirect, op, src, dst};
   endfunction

   // Two-word direct form with r0 as the source
   function automatic logic [15:0] imm_insn(input logic [2:0] pred, input alu_op_e op,
                                            input logic [3:0] dst);
      return insn_word(pred, 1'b1, 1'b0, op, 4'h0, dst);
   endfunction

   // ==================================================
   // Checks and test bookkeeping
   // ==================================================
   task automatic check_value(input logic [15:0] expected, input logic [15:0] actual);
      assert (actual == expected)
      else
      begin
         $display("FAILED %s: expected %h, actual %h", current_test, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("Error in %s: %s", current_test, what);
         error_count++;
      end
   endtask

   task automatic start_test(input string name);
      current_test    = name;
      errors_at_start = error_count;
   endtask

   task automatic finish_test();
      if (error_count == errors_at_start)
      begin
         tests_passed++;
         $display("test %s: pass", current_test);
      end
      else
      begin
         tests_failed++;
         $display("test %s: fail with %0d errors", current_test, error_count - errors_at_start);
      end
   endtask

   // ==================================================
   // APB host transfers
   // ==================================================
   task automatic apb_write(input logic [11:0] addr, input logic [15:0] data, output logic err);
      @(posedge clk);
      #2;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      apb_req.pwrite  = 1'b1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk);
      check_true(!apb_rsp.pready && !apb_rsp.pslverr, "response active in a setup cycle");
      @(posedge clk);
      #2;
      apb_req.penable = 1'b1;
      @(negedge clk);
      err = apb_rsp.pslverr;
      check_true(apb_rsp.pready, "pready low in an access cycle");
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [15:0] data, output logic err);
      @(posedge clk);
      #2;
      apb_req.paddr   = addr;
      apb_req.pwdata  = 16'h0;
      apb_req.pwrite  = 1'b0;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk);
      check_true(!apb_rsp.pready && !apb_rsp.pslverr, "response active in a setup cycle");
      @(posedge clk);
      #2;
      apb_req.penable = 1'b1;
      @(negedge clk);  // Read data is combinational and settled by mid-cycle
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      check_true(apb_rsp.pready, "pready low in an access cycle");
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic write_word(input logic [11:0] addr, input logic [15:0] data);
      logic err;
      apb_write(addr, data, err);
      check_true(!err, $sformatf("slave error on a write to address %h", addr));
   endtask

   task automatic read_word(input logic [11:0] addr, output logic [15:0] data);
      logic err;
      apb_read(addr, data, err);
      check_true(!err, $sformatf("slave error on a read of address %h", addr));
   endtask

   // ==================================================
   // Program table
   // ==================================================
   task automatic set_entry(input int idx, input string name, input logic [11:0] addr,
                            input logic [15:0] expected);
      prog_name[idx]        = name;
      prog_result_addr[idx] = addr;
      prog_expected[idx]    = expected;
   endtask

   task automatic fill_table();
      logic [15:0] jmp;
      jmp = imm_insn(p_al, op_ld, 4'hf);  // Loading r15 is a jump and serves as the halt loop
      set_entry(0, "add_imm", 12'h040, 16'h2143);
      prog_words[0] = '{imm_insn(p_al, op_ld, 4'h1), 16'h1234, imm_insn(p_al, op_add, 4'h1),
         16'h0f0f, imm_insn(p_al, op_sto, 4'h1), 16'h0040, jmp, 16'h0006,
         16'h0, 16'h0, 16'h0, 16'h0};
      set_entry(1, "and_imm", 12'h041, 16'h3030);
      prog_words[1] = '{imm_insn(p_al, op_ld, 4'h2), 16'hf0f0, imm_insn(p_al, op_and, 4'h2),
         16'h3c3c, imm_insn(p_al, op_sto, 4'h2), 16'h0041, jmp, 16'h0006,
         16'h0, 16'h0, 16'h0, 16'h0};
      set_entry(2, "or_imm", 12'h042, 16'ha555);
      prog_words[2] = '{imm_insn(p_al, op_ld, 4'h3), 16'ha005, imm_insn(p_al, op_or, 4'h3),
         16'h0550, imm_insn(p_al, op_sto, 4'h3), 16'h0042, jmp, 16'h0006,
         16'h0, 16'h0, 16'h0, 16'h0};
      set_entry(3, "xor_imm", 12'h043, 16'hf0f0);
      prog_words[3] = '{imm_insn(p_al, op_ld, 4'h4), 16'hff00, imm_insn(p_al, op_xor, 4'h4),
         16'h0ff0, imm_insn(p_al, op_sto, 4'h4), 16'h0043, jmp, 16'h0006,
         16'h0, 16'h0, 16'h0, 16'h0};
      // The add leaves carry set, which the rotate shifts in at the top
      set_entry(4, "ror_carry", 12'h044, 16'h8123);
      prog_words[4] = '{imm_insn(p_al, op_ld, 4'h5), 16'hffff, imm_insn(p_al, op_add, 4'h5),
         16'h0001, imm_insn(p_al, op_ror, 4'h6), 16'h0246, imm_insn(p_al, op_sto, 4'h6),
         16'h0044, jmp, 16'h0008, 16'h0, 16'h0};
      set_entry(5, "adc_carry", 12'h045, 16'h1235);
      prog_words[5] = '{imm_insn(p_al, op_ld, 4'h7), 16'h8000, imm_insn(p_al, op_add, 4'h7),
         16'h8001, imm_insn(p_al, op_ld, 4'h8), 16'h1000, imm_insn(p_al, op_adc, 4'h8),
         16'h0234, imm_insn(p_al, op_sto, 4'h8), 16'h0045, jmp, 16'h000a};
      // r9 + 3 points at the data word in slot 10
      set_entry(6, "indirect_load", 12'h046, 16'h5a3c);
      prog_words[6] = '{imm_insn(p_al, op_ld, 4'h9), 16'h0007,
         insn_word(p_al, 1'b1, 1'b1, op_ld, 4'h9, 4'ha), 16'h0003,
         imm_insn(p_al, op_sto, 4'ha), 16'h0046, jmp, 16'h0006,
         16'h0, 16'h0, 16'h5a3c, 16'h0};
      set_entry(7, "zero_taken", 12'h047, 16'h2222);
      prog_words[7] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hc),
         16'h0000, imm_insn(p_z, op_ld, 4'hb), 16'h2222, imm_insn(p_al, op_sto, 4'hb),
         16'h0047, jmp, 16'h0008, 16'h0, 16'h0};
      set_entry(8, "zero_skipped", 12'h048, 16'h1111);
      prog_words[8] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hc),
         16'h0005, imm_insn(p_z, op_ld, 4'hb), 16'h2222, imm_insn(p_al, op_sto, 4'hb),
         16'h0048, jmp, 16'h0008, 16'h0, 16'h0};
      set_entry(9, "nz_taken", 12'h049, 16'h3333);
      prog_words[9] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hc),
         16'h0005, imm_insn(p_nz, op_ld, 4'hb), 16'h3333, imm_insn(p_al, op_sto, 4'hb),
         16'h0049, jmp, 16'h0008, 16'h0, 16'h0};
      set_entry(10, "nz_skipped", 12'h04a, 16'h1111);
      prog_words[10] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hc),
         16'h0000, imm_insn(p_nz, op_ld, 4'hb), 16'h3333, imm_insn(p_al, op_sto, 4'hb),
         16'h004a, jmp, 16'h0008, 16'h0, 16'h0};
      set_entry(11, "carry_taken", 12'h04b, 16'h4444);
      prog_words[11] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hd),
         16'hffff, imm_insn(p_al, op_add, 4'hd), 16'h0001, imm_insn(p_c, op_ld, 4'hb),
         16'h4444, imm_insn(p_al, op_sto, 4'hb), 16'h004b, jmp, 16'h000a};
      set_entry(12, "carry_skipped", 12'h04c, 16'h1111);
      prog_words[12] = '{imm_insn(p_al, op_ld, 4'hb), 16'h1111, imm_insn(p_al, op_ld, 4'hd),
         16'h0001, imm_insn(p_al, op_add, 4'hd), 16'h0001, imm_insn(p_c, op_ld, 4'hb),
         16'h4444, imm_insn(p_al, op_sto, 4'hb), 16'h004c, jmp, 16'h000a};
      // The one-word form tests the predicate without an immediate fetch
      set_entry(13, "zero_one_word", 12'h04d, 16'h5555);
      prog_words[13] = '{imm_insn(p_al, op_ld, 4'he), 16'h5555, imm_insn(p_al, op_ld, 4'hc),
         16'h0000, insn_word(p_z, 1'b0, 1'b0, op_ld, 4'he, 4'hb),
         imm_insn(p_al, op_sto, 4'hb), 16'h004d, jmp, 16'h0007, 16'h0, 16'h0, 16'h0};
   endtask

   task automatic run_program(input int idx);
      logic [15:0] data;
      start_test(prog_name[idx]);
      write_word(ctrl_addr, 16'h0);
      write_word(prog_result_addr[idx], 16'hdead);  // Marker word stays if the store never happens
      for (int w = 0; w < 12; w++)
         write_word(12'(w), prog_words[idx][w]);
      write_word(ctrl_addr, 16'h1);
      repeat (run_cycles) @(posedge clk);
      write_word(ctrl_addr, 16'h0);
      read_word(prog_result_addr[idx], data);
      check_value(prog_expected[idx], data);
      finish_test();
   endtask

   // ==================================================
   // Test sequence
   // ==================================================
   initial
   begin
      logic [15:0] data;
      logic [15:0] value;
      logic [15:0] saved [16];
      logic        err;
      void'($urandom(3862));
      reset_b = 1'b0;
      apb_req = '0;
      fill_table();
      repeat (16) @(posedge clk);
      #2;
      reset_b = 1'b1;

      start_test("ctrl_reset_value");
      read_word(ctrl_addr, data);
      check_value(16'h0, data);
      finish_test();

      start_test("memory_round_trip");
      for (int i = 0; i < 16; i++)
      begin
         saved[i] = 16'($urandom);
         write_word(12'h020 + 12'(i), saved[i]);
      end
      for (int i = 0; i < 16; i++)
      begin
         read_word(12'h020 + 12'(i), data);
         check_value(saved[i], data);
      end
      finish_test();

      for (int t = 0; t < num_progs; t++)
         run_program(t);

      // Processor parks in a jump-to-self at address 0 while the host pokes memory
      start_test("write_while_running");
      value = 16'($urandom);
      write_word(12'h000, imm_insn(p_al, op_ld, 4'hf));
      write_word(12'h001, 16'h0000);
      write_word(12'h0f0, value);
      write_word(ctrl_addr, 16'h1);
      read_word(ctrl_addr, data);
      check_value(16'h1, data);
      apb_write(12'h0f0, ~value, err);
      check_true(err, "memory write while running gave no slave error");
      apb_read(12'h0f0, data, err);
      check_true(err, "memory read while running gave no slave error");
      check_value(16'h0, data);
      write_word(ctrl_addr, 16'h0);
      read_word(12'h0f0, data);
      check_value(value, data);
      finish_test();

      start_test("unmapped_address");
      value = 16'($urandom);
      write_word(12'h010, value);
      apb_write(12'h210, ~value, err);  // Same low bits as word 0x10
      check_true(err, "write to an unmapped address gave no slave error");
      apb_read(12'h210, data, err);
      check_true(err, "read of an unmapped address gave no slave error");
      check_value(16'h0, data);
      read_word(12'h010, data);
      check_value(value, data);
      finish_test();

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
               tests_passed + tests_failed, tests_passed, tests_failed, error_count);
      if (error_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- rtl/opc5_system.sv
`timescale 1ns/1ps

module opc5_system #(
   parameter int MEM_WORDS = 256
) (
   input  logic               clk,
   input  logic               reset_b,
   input  opc5_pkg::apb_req_t apb_req,
   output opc5_pkg::apb_rsp_t apb_rsp
);
   import opc5_pkg::*;

   cpu_bus_t    cpu_bus;    // Processor side request
   cpu_bus_t    mem_req;    // Request after host/processor selection
   logic [15:0] mem_rdata;
   logic        cpu_run;

   opc5_apb_port #(
      .MEM_WORDS (MEM_WORDS)
   ) apb_port_i (
      .clk       (clk),
      .reset_b   (reset_b),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .cpu_bus   (cpu_bus),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .cpu_run   (cpu_run)
   );

   opc5_memory #(
      .MEM_WORDS (MEM_WORDS)
   ) memory_i (
      .clk   (clk),
      .req   (mem_req),
      .rdata (mem_rdata)
   );

   opc5_cpu cpu_i (
      .clk     (clk),
      .reset_b (reset_b),
      .run     (cpu_run),
      .cpu_bus (cpu_bus),
      .rdata   (mem_rdata)
   );

endmodule

//--- rtl/opc5_apb_port.sv
`timescale 1ns/1ps

module opc5_apb_port #(
   parameter int MEM_WORDS = 256
) (
   input  logic               clk,
   input  logic               reset_b,
   input  opc5_pkg::apb_req_t apb_req,
   output opc5_pkg::apb_rsp_t apb_rsp,
   input  opc5_pkg::cpu_bus_t cpu_bus,
   output opc5_pkg::cpu_bus_t mem_req,
   input  logic [15:0]        mem_rdata,
   output logic               cpu_run
);
   import opc5_pkg::*;

   localparam logic [11:0] mem_limit = 12'(MEM_WORDS);

   logic run_q;
   logic access;
   logic hit_mem;
   logic hit_ctrl;
   logic err;

   assign access   = apb_req.psel && apb_req.penable;
   assign hit_mem  = (apb_req.paddr < mem_limit);
   assign hit_ctrl = (apb_req.paddr == ctrl_addr);
   // Memory belongs to the processor while it runs
   assign err      = (!hit_mem && !hit_ctrl) || (hit_mem && run_q);

   // ==================================================
   // Response and control register
   // ==================================================
   always_comb
   begin
      apb_rsp.pready  = access;  // Never any wait states
      apb_rsp.pslverr = access && err;
      apb_rsp.prdata  = 16'h0;
      if (access && !err)
      begin
         if (hit_ctrl)
            apb_rsp.prdata = {15'h0, run_q};
         else
            apb_rsp.prdata = mem_rdata;
      end
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         run_q <= 1'b0;
      else if (access && apb_req.pwrite && hit_ctrl)
         run_q <= apb_req.pwdata[0];
   end

   assign cpu_run = run_q;

   always_comb
   begin
      if (run_q)
         mem_req = cpu_bus;
      else
      begin
         mem_req.address = {4'h0, apb_req.paddr};
         mem_req.write   = access && apb_req.pwrite && hit_mem;
         mem_req.wdata   = apb_req.pwdata;
      end
   end

   a_penable_with_psel : assert property (@(posedge clk) disable iff (!reset_b)
      $rose(apb_req.penable) |-> apb_req.psel);

endmodule

//--- rtl/opc5_memory.sv
`timescale 1ns/1ps

module opc5_memory #(
   parameter int MEM_WORDS = 256
) (
   input  logic               clk,
   input  opc5_pkg::cpu_bus_t req,
   output logic [15:0]        rdata
);

   localparam int addr_bits = $clog2(MEM_WORDS);

   logic [15:0] mem [0:MEM_WORDS-1];

   // Upper address bits are ignored, so the space wraps
   assign rdata = mem[req.address[addr_bits-1:0]];

   always_ff @(posedge clk)
   begin
      if (req.write)
         mem[req.address[addr_bits-1:0]] <= req.wdata;
   end

endmodule

//--- rtl/opc5_cpu.sv
`timescale 1ns/1ps

module opc5_cpu (
   input  logic               clk,
   input  logic               reset_b,
   input  logic               run,
   output opc5_pkg::cpu_bus_t cpu_bus,
   input  logic [15:0]        rdata
);
   import opc5_pkg::*;

   fsm_state_e  state;
   logic [15:0] pc_q;
   logic [15:0] or_q;      // Holds the operand and then the effective address
   logic [15:0] ir_q;
   logic [15:0] result_q;  // Last written result that drives the zero flag
   logic        carry_q;
   logic [3:0]  rd_addr;
   logic [15:0] rd_data;
   logic [15:0] alu_result;
   logic        alu_carry;
   logic        dest_pc;

   assign dest_pc = (ir_q[3:0] == 4'hf);

   // ==================================================
   // Sub-blocks
   // ==================================================
   opc5_control control_i (
      .clk        (clk),
      .reset_b    (reset_b),
      .run        (run),
      .fetch_word (rdata),
      .ir         (ir_q),
      .carry_flag (carry_q),
      .zero_flag  (result_q == 16'h0),
      .src_zero   (ir_q[7:4] == 4'h0),
      .state      (state)
   );

   // Destination is read while executing or storing, source otherwise
   assign rd_addr = (state == exec || state == wrmem) ? ir_q[3:0] : ir_q[7:4];

   opc5_regfile regfile_i (
      .clk     (clk),
      .rd_addr (rd_addr),
      .pc      (pc_q),
      .rd_data (rd_data),
      .wr_en   (state == exec),
      .wr_addr (ir_q[3:0]),
      .wr_data (alu_result)
   );

   opc5_alu alu_i (
      .op        (alu_op_e'(ir_q[10:8])),
      .src       (rd_data),
      .operand   (or_q),
      .carry_in  (carry_q),
      .result    (alu_result),
      .carry_out (alu_carry)
   );

   // ==================================================
   // Memory request and datapath registers
   // ==================================================
   always_comb
   begin
      cpu_bus.address = (state == rdmem || state == wrmem) ? or_q : pc_q;
      cpu_bus.write   = (state == wrmem);
      cpu_bus.wdata   = rd_data;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc_q <= 16'h0;
      else if (!run)
         pc_q <= 16'h0;
      else if (state == fetch0 || state == fetch1)
         pc_q <= pc_q + 16'h1;
      else if (state == exec)
         pc_q <= dest_pc ? alu_result : pc_q + 16'h1;  // Writing r15 is a jump
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         carry_q  <= 1'b0;
         result_q <= 16'h0;
      end
      else if (!run)
      begin
         carry_q  <= 1'b0;
         result_q <= 16'h0;
      end
      else if (state == exec)
      begin
         carry_q  <= alu_carry;
         result_q <= alu_result;
      end
   end

   always_ff @(posedge clk)
   begin
      // Exec overlaps the fetch of the next instruction
      if (state == fetch0 || state == exec)
         ir_q <= rdata;
      case (state)
         fetch0, exec:
            or_q <= 16'h0;  // One-word forms start from a zero offset
         fetch1, rdmem:
            or_q <= rdata;
         ea_ed:
            or_q <= rd_data + or_q;
         default:
            or_q <= or_q;
      endcase
   end

   a_write_in_wrmem : assert property (@(posedge clk) disable iff (!reset_b)
      cpu_bus.write |-> (alu_op_e'(ir_q[10:8]) == op_sto) && ($past(state) == ea_ed));

endmodule

//--- rtl/opc5_alu.sv
`timescale 1ns/1ps

module opc5_alu (
   input  opc5_pkg::alu_op_e op,
   input  logic [15:0]       src,
   input  logic [15:0]       operand,
   input  logic              carry_in,
   output logic [15:0]       result,
   output logic              carry_out
);
   import opc5_pkg::*;

   logic [16:0] sum;

   // One adder serves both add forms
   assign sum = {1'b0, src} + {1'b0, operand} + {16'h0, carry_in && (op == op_adc)};

   always_comb
   begin
      result    = operand;
      carry_out = carry_in;  // Logic ops leave carry alone
      case (op)
         op_ld:
            result = operand;
         op_add, op_adc:
         begin
            result    = sum[15:0];
            carry_out = sum[16];
         end
         op_and:
            result = src & operand;
         op_or:
            result = src | operand;
         op_xor:
            result = src ^ operand;
         op_ror:
         begin
            // Old carry enters at the top, bit 0 drops into carry
            result    = {carry_in, operand[15:1]};
            carry_out = operand[0];
         end
         default:
            result = operand;  // Store has no register result
      endcase
   end

endmodule

//--- rtl/opc5_regfile.sv
`timescale 1ns/1ps

module opc5_regfile (
   input  logic        clk,
   input  logic [3:0]  rd_addr,
   input  logic [15:0] pc,
   output logic [15:0] rd_data,
   input  logic        wr_en,
   input  logic [3:0]  wr_addr,
   input  logic [15:0] wr_data
);

   logic [15:0] regs [0:14];

   // Register 15 lives in the datapath as the program counter
   always_ff @(posedge clk)
   begin
      if (wr_en && (wr_addr != 4'hf))
         regs[wr_addr] <= wr_data;
   end

   always_comb
   begin
      if (rd_addr == 4'h0)
         rd_data = 16'h0;  // Register 0 is hard wired to zero
      else if (rd_addr == 4'hf)
         rd_data = pc;
      else
         rd_data = regs[rd_addr];
   end

endmodule

//--- rtl/opc5_control.sv
`timescale 1ns/1ps

module opc5_control (
   input  logic                 clk,
   input  logic                 reset_b,
   input  logic                 run,
   input  logic [15:0]          fetch_word,
   input  logic [15:0]          ir,
   input  logic                 carry_flag,
   input  logic                 zero_flag,
   input  logic                 src_zero,
   output opc5_pkg::fsm_state_e state
);
   import opc5_pkg::*;

   logic       pred_word;
   logic       pred_ir;
   logic       is_sto;
   fsm_state_e next_state;

   // The word on the bus is only in the instruction register after fetch0
   assign pred_word = fetch_word[pinvert] ^ ((!fetch_word[pred_c] || carry_flag) &&
                                             (!fetch_word[pred_z] || zero_flag));
   assign pred_ir   = ir[pinvert] ^ ((!ir[pred_c] || carry_flag) && (!ir[pred_z] || zero_flag));
   assign is_sto    = (alu_op_e'(ir[10:8]) == op_sto);

   always_comb
   begin
      next_state = fetch0;
      case (state)
         fetch0:
            if (fetch_word[fsm_map0])
               next_state = fetch1;  // Two-word forms test the predicate in fetch1
            else if (pred_word)
               next_state = ea_ed;
         fetch1:
            if (!pred_ir)
               next_state = fetch0;
            else if (!src_zero || ir[fsm_map1] || is_sto)
               next_state = ea_ed;
            else
               next_state = exec;  // Immediate is already the full operand
         ea_ed:
            if (!pred_ir)
               next_state = fetch0;
            else if (ir[fsm_map1])
               next_state = rdmem;
            else if (is_sto)
               next_state = wrmem;
            else
               next_state = exec;
         rdmem:
            next_state = exec;
         exec:
            // A jump has to refetch from the new program counter
            if (ir[3:0] == 4'hf)
               next_state = fetch0;
            else if (fetch_word[fsm_map0])
               next_state = fetch1;
            else
               next_state = ea_ed;
         default:
            next_state = fetch0;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= fetch0;
      else if (!run)
         state <= fetch0;  // Stopped processor idles at the start state
      else
         state <= next_state;
   end

   a_state_defined : assert property (@(posedge clk) disable iff (!reset_b)
      state inside {fetch0, fetch1, ea_ed, rdmem, exec, wrmem});

   a_rdmem_to_exec : assert property (@(posedge clk) disable iff (!reset_b)
      (state == rdmem && run) |=> (state == exec));

endmodule

//--- rtl/opc5_pkg.sv
package opc5_pkg;

   // ==================================================
   // Instruction word fields
   // ==================================================
   localparam int pred_c   = 15;  // Carry predicate enable
   localparam int pred_z   = 14;  // Zero predicate enable
   localparam int pinvert  = 13;  // Inverts the predicate outcome
   localparam int fsm_map0 = 12;  // Immediate word follows
   localparam int fsm_map1 = 11;  // Operand is read from memory

   // Processor sequencing states
   typedef enum logic [2:0] {
      fetch0,
      fetch1,
      ea_ed,
      rdmem,
      exec,
      wrmem
   } fsm_state_e;

   // Opcode field, bits 10..8 of the instruction word
   typedef enum logic [2:0] {
      op_ld  = 3'b000,
      op_add = 3'b001,
      op_and = 3'b010,
      op_or  = 3'b011,
      op_xor = 3'b100,
      op_ror = 3'b101,
      op_adc = 3'b110,
      op_sto = 3'b111
   } alu_op_e;

   // ==================================================
   // Bus structures
   // ==================================================
   typedef struct packed {
      logic [15:0] address;
      logic        write;
      logic [15:0] wdata;
   } cpu_bus_t;

   typedef struct packed {
      logic [11:0] paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [15:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [15:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   localparam logic [11:0] ctrl_addr = 12'h100;  // Run control register

endpackage
